/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = apb_csr_tb
FILELIST  = apb_csr_top.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	elif ! grep -q "NO ERRORS" $(LOG); then \
	  echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* apb_csr_top.f */
hw/csr_pkg.sv
hw/apb_access.sv
hw/ctrl_regs.sv
hw/event_regs.sv
hw/apb_csr_top.sv
dv/apb_csr_checker.sv
dv/apb_csr_tb.sv

/* dv/apb_csr_checker.sv */
`timescale 1ns/1ps

module apb_csr_checker import csr_pkg::*; (
  input logic                   clk,
  input logic                   i_arst_n,
  input logic                   i_psel,
  input logic                   i_penable,
  input logic                   i_pready,
  input logic                   i_pslverr,
  input logic [FIELD_WIDTH-1:0] i_trigger
);

  // completion only inside an access phase
  assert property (@(posedge clk) disable iff (!i_arst_n)
    i_pready |-> (i_psel && i_penable))
    else $error("pready without psel and penable");

  assert property (@(posedge clk) disable iff (!i_arst_n)
    i_pslverr |-> i_pready)
    else $error("pslverr without pready");

  // pulses last one cycle
  assert property (@(posedge clk) disable iff (!i_arst_n)
    (|i_trigger) |=> ((i_trigger & $past(i_trigger)) == '0))
    else $error("trigger bit high for two cycles");

  assert property (@(posedge clk) !i_arst_n |-> (i_trigger == '0))
    else $error("trigger active during reset");

endmodule

/* dv/apb_csr_tb.sv */
`timescale 1ns/1ps

module apb_csr_tb import csr_pkg::*; ();

  localparam int                    ADDR_W         = 16;
  localparam logic [ADDR_W-1:0]     BASE           = 16'h1000;
  localparam logic [DATA_WIDTH-1:0] DEFAULT_RD     = 32'hdead_beaf;
  localparam logic [7:0]            CTRL_RESET     = 8'hc5;
  localparam int                    PREADY_TIMEOUT = 16;
  localparam logic [ADDR_W-1:0]     A_CTRL         = BASE + ADDR_W'(CTRL_OFFSET);
  localparam logic [ADDR_W-1:0]     A_TRIG         = BASE + ADDR_W'(TRIGGER_OFFSET);
  localparam logic [ADDR_W-1:0]     A_STATUS       = BASE + ADDR_W'(STATUS_OFFSET);
  localparam logic [ADDR_W-1:0]     A_HW           = BASE + ADDR_W'(HW_VALUE_OFFSET);

  logic                      clk;
  logic                      i_arst_n;
  logic                      i_psel;
  logic                      i_penable;
  logic [ADDR_W-1:0]         i_paddr;
  logic                      i_pwrite;
  logic [STRB_WIDTH-1:0]     i_pstrb;
  logic [DATA_WIDTH-1:0]     i_pwdata;
  logic [FIELD_WIDTH-1:0]    i_status_set;
  logic [HW_VALUE_WIDTH-1:0] i_hw_value;
  logic                      o_pready;
  logic [DATA_WIDTH-1:0]     o_prdata;
  logic                      o_pslverr;
  logic [FIELD_WIDTH-1:0]    o_ctrl_field0;
  logic [FIELD_WIDTH-1:0]    o_ctrl_field1;
  logic [FIELD_WIDTH-1:0]    o_trigger;

  // register model
  logic [2*FIELD_WIDTH-1:0]  model_ctrl;
  logic [FIELD_WIDTH-1:0]    model_status;
  logic [HW_VALUE_WIDTH-1:0] model_hw;

  logic [DATA_WIDTH-1:0] exp_data_q[$];
  logic                  exp_err_q[$];
  logic                  exp_chk_q[$]; // 0 for writes, data not compared
  logic [DATA_WIDTH-1:0] e_data;
  logic                  e_err;
  logic                  e_chk;
  logic [DATA_WIDTH-1:0] data;
  logic [STRB_WIDTH-1:0] strb;
  integer                seed;
  int                    errors;
  int                    tests;
  int                    failed_tests;
  int                    mark;

  apb_csr_top i_dut (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_psel        (i_psel),
    .i_penable     (i_penable),
    .i_paddr       (i_paddr),
    .i_pwrite      (i_pwrite),
    .i_pstrb       (i_pstrb),
    .i_pwdata      (i_pwdata),
    .i_status_set  (i_status_set),
    .i_hw_value    (i_hw_value),
    .o_pready      (o_pready),
    .o_prdata      (o_prdata),
    .o_pslverr     (o_pslverr),
    .o_ctrl_field0 (o_ctrl_field0),
    .o_ctrl_field1 (o_ctrl_field1),
    .o_trigger     (o_trigger)
  );

  bind apb_csr_top apb_csr_checker u_checker (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pready  (o_pready),
    .i_pslverr (o_pslverr),
    .i_trigger (o_trigger)
  );

  always #5 clk = ~clk;

  task automatic compare_data(input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic compare_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic compare_field(input logic [FIELD_WIDTH-1:0] got,
                               input logic [FIELD_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // expected read word and slave error for one access
  function automatic logic [DATA_WIDTH-1:0] ref_access(input logic [ADDR_W-1:0] addr,
                                                       input logic write, output logic err);
    int unsigned word;
    logic [DATA_WIDTH-1:0] rd;
    word = 32'(addr - BASE) & ~32'd3;
    rd   = '0;
    err  = 1'b0;
    if (addr < BASE || (addr - BASE) >= ADDR_W'(4 * REG_COUNT)) begin
      rd  = DEFAULT_RD;
      err = 1'b1;
    end else if (word == CTRL_OFFSET) begin
      rd = 32'(model_ctrl);
    end else if (word == STATUS_OFFSET) begin
      rd = 32'(model_status);
    end else if (word == HW_VALUE_OFFSET) begin
      rd  = 32'(model_hw);
      err = write; // read only
    end
    return rd;
  endfunction

  task automatic drive_transfer(input logic [ADDR_W-1:0] addr, input logic write,
                                input logic [DATA_WIDTH-1:0] wdata,
                                input logic [STRB_WIDTH-1:0] wstrb);
    int waited;
    waited = 0;
    @(posedge clk);
    i_psel    <= 1'b1;
    i_penable <= 1'b0;
    i_paddr   <= addr;
    i_pwrite  <= write;
    i_pwdata  <= wdata;
    i_pstrb   <= wstrb;
    @(posedge clk);
    i_penable <= 1'b1;
    @(negedge clk);
    while (!o_pready && waited < PREADY_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    // pready is due in the second access cycle
    if (!o_pready) begin
      $display("timeout: no pready within %0d cycles at address %h", PREADY_TIMEOUT, addr);
      errors++;
    end else if (waited != 1) begin
      $display("error at %0t ns: pready in access cycle %0d at address %h, expected 2",
               $time, waited + 1, addr);
      errors++;
    end
    @(posedge clk);
    i_psel    <= 1'b0;
    i_penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_WIDTH-1:0] wdata,
                           input logic [STRB_WIDTH-1:0] wstrb);
    drive_transfer(addr, 1'b1, wdata, wstrb);
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr);
    drive_transfer(addr, 1'b0, '0, '0);
  endtask

  task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_WIDTH-1:0] wdata,
                             input logic [STRB_WIDTH-1:0] wstrb);
    logic err;
    void'(ref_access(addr, 1'b1, err));
    exp_data_q.push_back('0);
    exp_err_q.push_back(err);
    exp_chk_q.push_back(1'b0);
    apb_write(addr, wdata, wstrb);
    if (!err && addr == A_CTRL && wstrb[0]) begin
      model_ctrl = wdata[2*FIELD_WIDTH-1:0];
    end else if (!err && addr == A_STATUS) begin
      model_status = model_status & ~wdata[FIELD_WIDTH-1:0];
    end
  endtask

  task automatic expect_read(input logic [ADDR_W-1:0] addr);
    logic err;
    exp_data_q.push_back(ref_access(addr, 1'b0, err));
    exp_err_q.push_back(err);
    exp_chk_q.push_back(1'b1);
    apb_read(addr);
  endtask

  task automatic pulse_status(input logic [FIELD_WIDTH-1:0] bits);
    @(posedge clk);
    i_status_set <= bits;
    @(posedge clk);
    i_status_set <= '0;
    model_status = model_status | bits;
  endtask

  task automatic check_ctrl_ports();
    @(negedge clk);
    compare_field(o_ctrl_field0, model_ctrl[FIELD_WIDTH-1:0], "ctrl_field0");
    compare_field(o_ctrl_field1, model_ctrl[2*FIELD_WIDTH-1:FIELD_WIDTH], "ctrl_field1");
  endtask

  task automatic close_test(input string name);
    tests++;
    if (errors == mark) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - mark);
      failed_tests++;
    end
    mark = errors;
  endtask

  // response checker, one compare per completed transfer
  always @(negedge clk) begin
    if (i_arst_n && o_pready) begin
      if (exp_err_q.size() == 0) begin
        $display("pready at %0t ns with no transfer pending", $time);
        errors++;
      end else begin
        e_err  = exp_err_q.pop_front();
        e_data = exp_data_q.pop_front();
        e_chk  = exp_chk_q.pop_front();
        compare_err(o_pslverr, e_err, $sformatf("pslverr at %h", i_paddr));
        if (e_chk) begin
          compare_data(o_prdata, e_data, $sformatf("prdata at %h", i_paddr));
        end
      end
    end
  end

  initial begin
    seed         = 32'he7bd_5d52;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    mark         = 0;
    clk          = 1'b0;
    i_arst_n     = 1'b1;
    i_psel       = 1'b0;
    i_penable    = 1'b0;
    i_paddr      = '0;
    i_pwrite     = 1'b0;
    i_pstrb      = '0;
    i_pwdata     = '0;
    i_status_set = '0;
    model_hw     = 8'h5a;
    i_hw_value   = model_hw;
    model_ctrl   = CTRL_RESET;
    model_status = '0;
    @(posedge clk);
    i_arst_n <= 1'b0;
    repeat (2) @(posedge clk);
    i_arst_n <= 1'b1;

    check_ctrl_ports();
    expect_read(A_CTRL);
    expect_read(A_STATUS);
    close_test("reset values");

    repeat (8) begin
      data = $random(seed);
      strb = STRB_WIDTH'($random(seed));
      model_write(A_CTRL, data, strb);
      check_ctrl_ports();
      expect_read(A_CTRL);
    end
    model_write(A_CTRL, 32'h0000_00ff ^ 32'(model_ctrl), 4'b1110); // lane 0 off
    check_ctrl_ports();
    expect_read(A_CTRL);
    close_test("control writes");

    repeat (4) begin
      data = $random(seed);
      model_write(A_TRIG, data, 4'hf);
      @(negedge clk);
      compare_field(o_trigger, data[FIELD_WIDTH-1:0], "trigger pulse");
      @(negedge clk);
      compare_field(o_trigger, '0, "trigger after pulse");
    end
    expect_read(A_TRIG);
    close_test("trigger");

    pulse_status(4'b1010);
    expect_read(A_STATUS);
    model_write(A_STATUS, 32'h0000_0002, 4'hf);
    expect_read(A_STATUS);
    pulse_status(4'b0100);
    fork
      model_write(A_STATUS, 32'h0000_0004, 4'hf);
      begin
        repeat (3) @(posedge clk);
        i_status_set <= 4'b0100; // lands on the clearing edge
        @(posedge clk);
        i_status_set <= '0;
      end
    join
    model_status = model_status | 4'b0100;
    expect_read(A_STATUS);
    close_test("status");

    @(posedge clk);
    model_hw = HW_VALUE_WIDTH'($random(seed));
    i_hw_value <= model_hw;
    expect_read(A_HW);
    model_write(A_HW, $random(seed), 4'hf);
    expect_read(A_HW);
    expect_read(A_CTRL);
    close_test("hardware value");

    expect_read(BASE + 16'h10);
    expect_read(BASE - 16'h4);
    model_write(BASE + 16'h10, 32'hffff_ffff, 4'hf);
    check_ctrl_ports();
    compare_field(o_trigger, '0, "trigger after unmapped write");
    expect_read(A_CTRL);
    expect_read(A_STATUS);
    close_test("unmapped addresses");

    if (exp_err_q.size() != 0) begin
      $display("%0d transfers never completed", exp_err_q.size());
      errors++;
    end
    $display("tests: %0d, failed: %0d, errors: %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* hw/apb_access.sv */
`timescale 1ns/1ps

module apb_access import csr_pkg::*; #(
  parameter int                    ADDR_WIDTH        = 16,
  parameter logic [ADDR_WIDTH-1:0] BASE_ADDRESS      = 'h1000,
  parameter logic [DATA_WIDTH-1:0] DEFAULT_READ_DATA = 32'hdead_beaf
) (
  input  logic                      clk,
  input  logic                      i_arst_n,
  input  logic                      i_psel,
  input  logic                      i_penable,
  input  logic [ADDR_WIDTH-1:0]     i_paddr,
  input  logic                      i_pwrite,
  input  logic [STRB_WIDTH-1:0]     i_pstrb,
  input  logic [DATA_WIDTH-1:0]     i_pwdata,
  output logic                      o_pready,
  output logic [DATA_WIDTH-1:0]     o_prdata,
  output logic                      o_pslverr,
  input  logic [2*FIELD_WIDTH-1:0]  i_ctrl_value,
  input  logic [FIELD_WIDTH-1:0]    i_status_value,
  input  logic [HW_VALUE_WIDTH-1:0] i_hw_value,
  output logic                      o_ctrl_write,
  output logic                      o_event_write,
  output logic                      o_event_select,
  output logic [DATA_WIDTH-1:0]     o_wdata,
  output logic [STRB_WIDTH-1:0]     o_wstrb
);

  localparam logic [ADDR_WIDTH-1:0] MAP_SIZE = ADDR_WIDTH'(REG_COUNT * 4);

  logic [ADDR_WIDTH-1:0] offset;
  logic [ADDR_WIDTH-1:0] word_offset;
  logic                  mapped;
  logic                  hit_ctrl;
  logic                  hit_trigger;
  logic                  hit_status;
  logic                  hit_hw;
  logic                  slverr;
  logic                  access_phase;
  logic [DATA_WIDTH-1:0] rdata;
  logic                  pready_q;
  logic                  pslverr_q;
  logic [DATA_WIDTH-1:0] prdata_q;

  // address decode relative to the block base
  assign offset      = i_paddr - BASE_ADDRESS;
  assign word_offset = {offset[ADDR_WIDTH-1:2], 2'b00};
  assign mapped      = (i_paddr >= BASE_ADDRESS) && (offset < MAP_SIZE);

  assign hit_ctrl    = mapped && (word_offset == ADDR_WIDTH'(CTRL_OFFSET));
  assign hit_trigger = mapped && (word_offset == ADDR_WIDTH'(TRIGGER_OFFSET));
  assign hit_status  = mapped && (word_offset == ADDR_WIDTH'(STATUS_OFFSET));
  assign hit_hw      = mapped && (word_offset == ADDR_WIDTH'(HW_VALUE_OFFSET));

  assign slverr = !mapped || (hit_hw && i_pwrite); // hw value is read only

  always_comb begin
    rdata = '0;
    if (!mapped) begin
      rdata = DEFAULT_READ_DATA;
    end else if (hit_ctrl) begin
      rdata[2*FIELD_WIDTH-1:0] = i_ctrl_value;
    end else if (hit_status) begin
      rdata[FIELD_WIDTH-1:0] = i_status_value;
    end else if (hit_hw) begin
      rdata[HW_VALUE_WIDTH-1:0] = i_hw_value;
    end
    // trigger falls through and reads zero
  end

  // first access cycle, pready follows one cycle later
  assign access_phase = i_psel && i_penable && !pready_q;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
    end else begin
      pready_q  <= access_phase;
      pslverr_q <= access_phase && slverr;
    end
  end

  always_ff @(posedge clk) begin
    if (access_phase) begin
      prdata_q <= rdata;
    end
  end

  assign o_pready  = pready_q;
  assign o_pslverr = pslverr_q;
  assign o_prdata  = prdata_q;

  // strobes fire in the completing cycle
  assign o_ctrl_write   = pready_q && i_pwrite && hit_ctrl;
  assign o_event_write  = pready_q && i_pwrite && (hit_trigger || hit_status);
  assign o_event_select = offset[3];  // 0 trigger, 1 status
  assign o_wdata        = i_pwdata;
  assign o_wstrb        = i_pstrb;

endmodule

/* hw/apb_csr_top.sv */
`timescale 1ns/1ps

module apb_csr_top import csr_pkg::*; #(
  parameter int                      ADDR_WIDTH        = 16,
  parameter logic [ADDR_WIDTH-1:0]   BASE_ADDRESS      = 'h1000,
  parameter logic [DATA_WIDTH-1:0]   DEFAULT_READ_DATA = 32'hdead_beaf,
  parameter logic [2*FIELD_WIDTH-1:0] CTRL_INIT        = 8'hc5
) (
  input  logic                      clk,
  input  logic                      i_arst_n,
  input  logic                      i_psel,
  input  logic                      i_penable,
  input  logic [ADDR_WIDTH-1:0]     i_paddr,
  input  logic                      i_pwrite,
  input  logic [STRB_WIDTH-1:0]     i_pstrb,
  input  logic [DATA_WIDTH-1:0]     i_pwdata,
  input  logic [FIELD_WIDTH-1:0]    i_status_set,
  input  logic [HW_VALUE_WIDTH-1:0] i_hw_value,
  output logic                      o_pready,
  output logic [DATA_WIDTH-1:0]     o_prdata,
  output logic                      o_pslverr,
  output logic [FIELD_WIDTH-1:0]    o_ctrl_field0,
  output logic [FIELD_WIDTH-1:0]    o_ctrl_field1,
  output logic [FIELD_WIDTH-1:0]    o_trigger
);

  logic [2*FIELD_WIDTH-1:0] ctrl_value;
  logic [FIELD_WIDTH-1:0]   status_value;
  logic                     ctrl_write;
  logic                     event_write;
  logic                     event_select;
  logic [DATA_WIDTH-1:0]    wdata;
  logic [STRB_WIDTH-1:0]    wstrb;

  assign o_ctrl_field0 = ctrl_value[FIELD_WIDTH-1:0];
  assign o_ctrl_field1 = ctrl_value[2*FIELD_WIDTH-1:FIELD_WIDTH];

  apb_access #(
    .ADDR_WIDTH        (ADDR_WIDTH),
    .BASE_ADDRESS      (BASE_ADDRESS),
    .DEFAULT_READ_DATA (DEFAULT_READ_DATA)
  ) u_apb_access (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_psel         (i_psel),
    .i_penable      (i_penable),
    .i_paddr        (i_paddr),
    .i_pwrite       (i_pwrite),
    .i_pstrb        (i_pstrb),
    .i_pwdata       (i_pwdata),
    .o_pready       (o_pready),
    .o_prdata       (o_prdata),
    .o_pslverr      (o_pslverr),
    .i_ctrl_value   (ctrl_value),
    .i_status_value (status_value),
    .i_hw_value     (i_hw_value),
    .o_ctrl_write   (ctrl_write),
    .o_event_write  (event_write),
    .o_event_select (event_select),
    .o_wdata        (wdata),
    .o_wstrb        (wstrb)
  );

  ctrl_regs #(
    .CTRL_INIT (CTRL_INIT)
  ) u_ctrl_regs (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_write      (ctrl_write),
    .i_wdata      (wdata),
    .i_wstrb      (wstrb),
    .o_ctrl_value (ctrl_value)
  );

  event_regs u_event_regs (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_write        (event_write),
    .i_event_select (event_select),
    .i_wdata        (wdata[FIELD_WIDTH-1:0]),
    .i_status_set   (i_status_set),
    .o_trigger      (o_trigger),
    .o_status_value (status_value)
  );

endmodule

/* hw/csr_pkg.sv */
package csr_pkg;

  // APB data path
  parameter int DATA_WIDTH = 32;
  parameter int STRB_WIDTH = DATA_WIDTH / 8;

  // field widths
  parameter int FIELD_WIDTH    = 4;
  parameter int HW_VALUE_WIDTH = 8;

  // word offsets from the block base address
  parameter int unsigned CTRL_OFFSET     = 'h0;
  parameter int unsigned TRIGGER_OFFSET  = 'h4;
  parameter int unsigned STATUS_OFFSET   = 'h8;
  parameter int unsigned HW_VALUE_OFFSET = 'hc;

  parameter int unsigned REG_COUNT = 4;

endpackage

/* hw/ctrl_regs.sv */
`timescale 1ns/1ps

module ctrl_regs import csr_pkg::*; #(
  parameter logic [2*FIELD_WIDTH-1:0] CTRL_INIT = 8'hc5
) (
  input  logic                     clk,
  input  logic                     i_arst_n,
  input  logic                     i_write,
  input  logic [DATA_WIDTH-1:0]    i_wdata,
  input  logic [STRB_WIDTH-1:0]    i_wstrb,
  output logic [2*FIELD_WIDTH-1:0] o_ctrl_value
);

  localparam int CTRL_BITS = 2 * FIELD_WIDTH;

  logic [CTRL_BITS-1:0] bit_mask;
  logic [CTRL_BITS-1:0] ctrl_next;
  logic [CTRL_BITS-1:0] ctrl_q;

  // expand byte strobes to the register bits
  always_comb begin
    for (int i = 0; i < CTRL_BITS; i++) begin
      bit_mask[i] = i_wstrb[i/8];
    end
  end

  assign ctrl_next = (ctrl_q & ~bit_mask) | (i_wdata[CTRL_BITS-1:0] & bit_mask);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ctrl_q <= CTRL_INIT;
    end else if (i_write) begin
      ctrl_q <= ctrl_next;
    end
  end

  assign o_ctrl_value = ctrl_q; // field1 in upper nibble

endmodule

/* hw/event_regs.sv */
`timescale 1ns/1ps

module event_regs import csr_pkg::*; (
  input  logic                   clk,
  input  logic                   i_arst_n,
  input  logic                   i_write,
  input  logic                   i_event_select,
  input  logic [FIELD_WIDTH-1:0] i_wdata,
  input  logic [FIELD_WIDTH-1:0] i_status_set,
  output logic [FIELD_WIDTH-1:0] o_trigger,
  output logic [FIELD_WIDTH-1:0] o_status_value
);

  logic                   trigger_write;
  logic                   status_write;
  logic [FIELD_WIDTH-1:0] status_clear;
  logic [FIELD_WIDTH-1:0] trigger_q;
  logic [FIELD_WIDTH-1:0] status_q;

  assign trigger_write = i_write && !i_event_select;
  assign status_write  = i_write && i_event_select;
  assign status_clear  = status_write ? i_wdata : '0;

  // written ones become a single-cycle pulse
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      trigger_q <= '0;
    end else begin
      trigger_q <= trigger_write ? i_wdata : '0;
    end
  end

  // hardware set wins over a clear in the same cycle
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~status_clear) | i_status_set;
    end
  end

  assign o_trigger      = trigger_q;
  assign o_status_value = status_q;

endmodule
